/* verilog/btbPkg.sv */
/*
 * Shared sizes, entry layouts and PC slicing helpers for the branch target
 * buffer. Design files refer to everything here by scoped name.
 */
package btbPkg;

    // Superscalar widths
    localparam int FETCH_WIDTH = 2;
    localparam int ISSUE_WIDTH = 2;

    // Table geometry, bank is the low index bit
    localparam int ENTRY_NUM  = 64;
    localparam int INDEX_BITS = 6;
    localparam int BANK_NUM   = 2;
    localparam int BANK_BITS  = $clog2(BANK_NUM);
    localparam int ROW_NUM    = ENTRY_NUM / BANK_NUM;
    localparam int ROW_BITS   = INDEX_BITS - BANK_BITS;

    localparam int QUEUE_SIZE     = 4;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_SIZE);

    localparam int INSN_BYTES  = 4;
    localparam int OFFSET_BITS = $clog2(INSN_BYTES);
    localparam int PC_BITS     = 32;
    localparam int TAG_BITS    = 8;
    localparam int WORD_BITS   = PC_BITS - OFFSET_BITS;

    typedef logic [PC_BITS-1:0]        pcT;
    typedef logic [INDEX_BITS-1:0]     indexT;
    typedef logic [TAG_BITS-1:0]       tagT;
    typedef logic [BANK_BITS-1:0]      bankT;
    typedef logic [ROW_BITS-1:0]       rowT;
    typedef logic [WORD_BITS-1:0]      wordAddrT;
    typedef logic [QUEUE_PTR_BITS-1:0] queuePtrT;
    typedef logic [QUEUE_PTR_BITS:0]   queueCountT;

    // Target kept as a word address
    typedef struct packed {
        logic     valid;
        logic     isCondBr;
        tagT      tag;
        wordAddrT target;
    } btbEntryT;

    typedef struct packed {
        indexT    index;
        btbEntryT entry;
    } queueEntryT;

    function automatic indexT toIndex(pcT pc);
        return pc[OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic tagT toTag(pcT pc);
        return pc[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    endfunction

    function automatic bankT bankOf(indexT index);
        return index[BANK_BITS-1:0];
    endfunction

    // Row inside a bank
    function automatic rowT rowOf(indexT index);
        return index[INDEX_BITS-1:BANK_BITS];
    endfunction

endpackage

/* verilog/btbWriteIf.sv */
/*
 * Write side of the banked entry array. The update arbiter drives one
 * strobe, index and entry per issue port; the array samples them on clk.
 */
`timescale 1ns/1ps

interface btbWriteIf #(
    parameter int ENTRY_BITS = $bits(btbPkg::btbEntryT)
) (
    input logic clk
);

    // Plain per-cycle strobes, no handshake
    logic                  we [btbPkg::ISSUE_WIDTH];
    btbPkg::indexT         wa [btbPkg::ISSUE_WIDTH];
    logic [ENTRY_BITS-1:0] wv [btbPkg::ISSUE_WIDTH];

    modport master (
        input  clk,
        output we,
        output wa,
        output wv
    );

    modport slave (
        input clk,
        input we,
        input wa,
        input wv
    );

endinterface

/* verilog/multiBankRam.sv */
/*
 * Banked synchronous RAM for the BTB entries. Write ports come in through
 * btbWriteIf, one read port per fetch slot returns data a cycle later.
 * A read of an address written in the same cycle sees the old contents.
 */
`timescale 1ns/1ps

module multiBankRam #(
    parameter int ENTRY_BITS = $bits(btbPkg::btbEntryT)
) (
    btbWriteIf.slave              wr,
    input  btbPkg::indexT         ra [btbPkg::FETCH_WIDTH],
    output logic [ENTRY_BITS-1:0] rv [btbPkg::FETCH_WIDTH]
);

    // One row array per bank
    logic [ENTRY_BITS-1:0] bankMem [btbPkg::BANK_NUM][btbPkg::ROW_NUM];

    always_ff @(posedge wr.clk) begin
        for (int p = 0; p < btbPkg::ISSUE_WIDTH; p++) begin
            if (wr.we[p]) begin
                bankMem[btbPkg::bankOf(wr.wa[p])][btbPkg::rowOf(wr.wa[p])] <= wr.wv[p];
            end
        end
    end

    // Registered reads, nonblocking so a colliding write is not forwarded
    always_ff @(posedge wr.clk) begin
        for (int r = 0; r < btbPkg::FETCH_WIDTH; r++) begin
            rv[r] <= bankMem[btbPkg::bankOf(ra[r])][btbPkg::rowOf(ra[r])];
        end
    end

    // Each bank has a single write port, so the arbiter must keep writes apart
    for (genvar i = 0; i < btbPkg::ISSUE_WIDTH; i++) begin : gWrA
        for (genvar j = i + 1; j < btbPkg::ISSUE_WIDTH; j++) begin : gWrB
            aWriteBankUnique : assert property (
                @(posedge wr.clk)
                !(wr.we[i] && wr.we[j] &&
                  btbPkg::bankOf(wr.wa[i]) == btbPkg::bankOf(wr.wa[j]))
            ) else begin
                $error("Write ports %0d and %0d hit bank %0d together",
                       i, j, btbPkg::bankOf(wr.wa[i]));
            end
        end
    end

endmodule

/* verilog/btbUpdateArbiter.sv */
/*
 * Turns executed branch results into BTB array writes. Bank conflicts are
 * parked in a small queue and replayed on free ports; after reset a sweep
 * clears every entry through port 0 and then raises ready.
 */
`timescale 1ns/1ps

module btbUpdateArbiter (
    input  logic       clk,
    input  logic       rstN,
    input  logic       brValid    [btbPkg::ISSUE_WIDTH],
    input  logic       brTaken    [btbPkg::ISSUE_WIDTH],
    input  logic       brIsCondBr [btbPkg::ISSUE_WIDTH],
    input  btbPkg::pcT brAddr     [btbPkg::ISSUE_WIDTH],
    input  btbPkg::pcT brNextAddr [btbPkg::ISSUE_WIDTH],
    btbWriteIf.master  wr,
    output logic       ready
);

    typedef enum logic [1:0] {
        sInit,
        sSweep,
        sRun
    } stateT;

    stateT         state;
    btbPkg::indexT sweepIdx;

    logic             we [btbPkg::ISSUE_WIDTH];
    btbPkg::indexT    wa [btbPkg::ISSUE_WIDTH];
    btbPkg::btbEntryT wv [btbPkg::ISSUE_WIDTH];

    btbPkg::queueEntryT queueMem [btbPkg::QUEUE_SIZE];
    btbPkg::queuePtrT   headPtr;
    btbPkg::queuePtrT   tailPtr;
    btbPkg::queueCountT count;
    btbPkg::queueEntryT head;
    btbPkg::queueEntryT pushEntry;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    assign ready = (state == sRun);
    assign full  = (count == btbPkg::queueCountT'(btbPkg::QUEUE_SIZE));
    assign empty = (count == '0);
    assign head  = queueMem[headPtr];

    always_comb begin
        logic blocked;
        push      = 1'b0;
        pop       = 1'b0;
        pushEntry = '0;
        blocked   = 1'b0;

        // One candidate per taken result, nothing before ready
        for (int i = 0; i < btbPkg::ISSUE_WIDTH; i++) begin
            we[i]          = ready && brValid[i] && brTaken[i];
            wa[i]          = btbPkg::toIndex(brAddr[i]);
            wv[i].valid    = 1'b1;
            wv[i].isCondBr = brIsCondBr[i];
            wv[i].tag      = btbPkg::toTag(brAddr[i]);
            wv[i].target   = brNextAddr[i][btbPkg::PC_BITS-1:btbPkg::OFFSET_BITS];
        end

        // Later ports yield the bank to earlier ones; a full queue drops the update
        for (int i = 1; i < btbPkg::ISSUE_WIDTH; i++) begin
            for (int j = 0; j < i; j++) begin
                if (we[i] && we[j] && btbPkg::bankOf(wa[i]) == btbPkg::bankOf(wa[j])) begin
                    we[i]           = 1'b0;
                    push            = !full;
                    pushEntry.index = wa[i];
                    pushEntry.entry = wv[i];
                end
            end
        end

        // Replay the head on the first idle port that stays conflict free
        if (!empty) begin
            for (int i = 0; i < btbPkg::ISSUE_WIDTH; i++) begin
                blocked = we[i] || pop;
                for (int j = 0; j < btbPkg::ISSUE_WIDTH; j++) begin
                    if (j != i && we[j] &&
                        btbPkg::bankOf(head.index) == btbPkg::bankOf(wa[j])) begin
                        blocked = 1'b1;
                    end
                end
                if (!blocked) begin
                    we[i] = 1'b1;
                    wa[i] = head.index;
                    wv[i] = head.entry;
                    pop   = 1'b1;
                end
            end
        end

        // Sweep owns port 0 and silences the rest
        if (state == sSweep) begin
            for (int i = 0; i < btbPkg::ISSUE_WIDTH; i++) begin
                we[i] = (i == 0);
                wa[i] = sweepIdx;
                wv[i] = '0;
            end
            push = 1'b0;
            pop  = 1'b0;
        end
    end

    always_comb begin
        for (int i = 0; i < btbPkg::ISSUE_WIDTH; i++) begin
            wr.we[i] = we[i];
            wr.wa[i] = wa[i];
            wr.wv[i] = wv[i];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= sInit;
            sweepIdx <= '0;
            headPtr  <= '0;
            tailPtr  <= '0;
            count    <= '0;
        end else begin
            case (state)
                sInit: state <= sSweep;
                sSweep: begin
                    sweepIdx <= sweepIdx + 1'b1;
                    if (sweepIdx == btbPkg::indexT'(btbPkg::ENTRY_NUM - 1)) begin
                        state <= sRun;
                    end
                end
                default: state <= sRun;
            endcase

            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= headPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queueMem[tailPtr] <= pushEntry;
        end
    end

    // Direct writes and the replayed head together must still spread over banks
    for (genvar i = 0; i < btbPkg::ISSUE_WIDTH; i++) begin : gPortA
        for (genvar j = i + 1; j < btbPkg::ISSUE_WIDTH; j++) begin : gPortB
            aPortBankUnique : assert property (
                @(posedge clk) disable iff (!rstN)
                !(wr.we[i] && wr.we[j] &&
                  btbPkg::bankOf(wr.wa[i]) == btbPkg::bankOf(wr.wa[j]))
            ) else begin
                $error("Arbiter enabled ports %0d and %0d on one bank", i, j);
            end
        end
    end

endmodule

/* verilog/btbReadStage.sv */
/*
 * Lookup side of the BTB. Sends one read index per fetch slot to the array,
 * keeps the slot tags for a cycle and compares them with the returned entries.
 */
`timescale 1ns/1ps

module btbReadStage (
    input  logic             clk,
    input  logic             rstN,
    input  btbPkg::pcT       predNextPc,
    output btbPkg::indexT    ra          [btbPkg::FETCH_WIDTH],
    input  btbPkg::btbEntryT rv          [btbPkg::FETCH_WIDTH],
    output logic             btbHit      [btbPkg::FETCH_WIDTH],
    output btbPkg::pcT       btbTarget   [btbPkg::FETCH_WIDTH],
    output logic             btbIsCondBr [btbPkg::FETCH_WIDTH]
);

    btbPkg::pcT  slotPc [btbPkg::FETCH_WIDTH];
    btbPkg::tagT tagReg [btbPkg::FETCH_WIDTH];

    // Slot i covers the i-th instruction after the predicted PC
    always_comb begin
        for (int i = 0; i < btbPkg::FETCH_WIDTH; i++) begin
            slotPc[i] = predNextPc + btbPkg::pcT'(i * btbPkg::INSN_BYTES);
            ra[i]     = btbPkg::toIndex(slotPc[i]);
        end
    end

    // Tags line up with the array data one cycle later
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < btbPkg::FETCH_WIDTH; i++) begin
                tagReg[i] <= '0;
            end
        end else begin
            for (int i = 0; i < btbPkg::FETCH_WIDTH; i++) begin
                tagReg[i] <= btbPkg::toTag(slotPc[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < btbPkg::FETCH_WIDTH; i++) begin
            btbHit[i]      = rv[i].valid && (rv[i].tag == tagReg[i]);
            btbTarget[i]   = {rv[i].target, {btbPkg::OFFSET_BITS{1'b0}}};
            btbIsCondBr[i] = rv[i].isCondBr;
        end
    end

endmodule

/* verilog/btb.sv */
/*
 * Branch target buffer for the fetch stage. Looks up FETCH_WIDTH slots per
 * cycle from predNextPc and learns taken targets from the branch result ports.
 * Results are valid from the cycle after the lookup, once ready is high.
 */
`timescale 1ns/1ps

module btb (
    input  logic       clk,
    input  logic       rstN,
    input  btbPkg::pcT predNextPc,
    input  logic       brValid     [btbPkg::ISSUE_WIDTH],
    input  logic       brTaken     [btbPkg::ISSUE_WIDTH],
    input  logic       brIsCondBr  [btbPkg::ISSUE_WIDTH],
    input  btbPkg::pcT brAddr      [btbPkg::ISSUE_WIDTH],
    input  btbPkg::pcT brNextAddr  [btbPkg::ISSUE_WIDTH],
    output logic       ready,
    output logic       btbHit      [btbPkg::FETCH_WIDTH],
    output btbPkg::pcT btbTarget   [btbPkg::FETCH_WIDTH],
    output logic       btbIsCondBr [btbPkg::FETCH_WIDTH]
);

    // Read path between lookup stage and array
    btbPkg::indexT    readAddr [btbPkg::FETCH_WIDTH];
    btbPkg::btbEntryT readData [btbPkg::FETCH_WIDTH];

    btbWriteIf #(
        .ENTRY_BITS($bits(btbPkg::btbEntryT))
    ) u_wrIf (
        .clk(clk)
    );

    btbUpdateArbiter u_updateArbiter (
        .clk       (clk),
        .rstN      (rstN),
        .brValid   (brValid),
        .brTaken   (brTaken),
        .brIsCondBr(brIsCondBr),
        .brAddr    (brAddr),
        .brNextAddr(brNextAddr),
        .wr        (u_wrIf.master),
        .ready     (ready)
    );

    btbReadStage u_readStage (
        .clk        (clk),
        .rstN       (rstN),
        .predNextPc (predNextPc),
        .ra         (readAddr),
        .rv         (readData),
        .btbHit     (btbHit),
        .btbTarget  (btbTarget),
        .btbIsCondBr(btbIsCondBr)
    );

    multiBankRam #(
        .ENTRY_BITS($bits(btbPkg::btbEntryT))
    ) u_ram (
        .wr(u_wrIf.slave),
        .ra(readAddr),
        .rv(readData)
    );

endmodule

/* dv/btbTb.sv */
/*
 * Testbench for the BTB. Drives directed and random fetch lookups and branch
 * results, keeps a reference table and checks every lookup after ready rises.
 */
`timescale 1ns/1ps

module btbTb;

    localparam int SLOTS         = btbPkg::FETCH_WIDTH;
    localparam int PORTS         = btbPkg::ISSUE_WIDTH;
    localparam int DRAIN_CYCLES  = btbPkg::QUEUE_SIZE + 2;
    localparam int RANDOM_CYCLES = 2000;
    localparam int MAX_CYCLES    = btbPkg::ENTRY_NUM + 10 + RANDOM_CYCLES + 200;

    typedef struct packed {
        logic        valid;
        logic        cond;
        logic [7:0]  tag;
        logic [31:0] target;
    } refEntryT;

    logic       clk;
    logic       rstN;
    btbPkg::pcT predNextPc;
    logic       brValid     [PORTS];
    logic       brTaken     [PORTS];
    logic       brIsCondBr  [PORTS];
    btbPkg::pcT brAddr      [PORTS];
    btbPkg::pcT brNextAddr  [PORTS];
    logic       ready;
    logic       btbHit      [SLOTS];
    btbPkg::pcT btbTarget   [SLOTS];
    logic       btbIsCondBr [SLOTS];

    // Reference table, plus a second allowed value while a queued write drains
    refEntryT refTable  [btbPkg::ENTRY_NUM];
    refEntryT pendEntry [btbPkg::ENTRY_NUM];
    int       pendCnt   [btbPkg::ENTRY_NUM];

    refEntryT   expNow   [SLOTS];
    refEntryT   expAlt   [SLOTS];
    logic       expAltOn [SLOTS];
    logic [7:0] expTag   [SLOTS];
    logic       expOn  = 1'b0;
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;

    btb u_btb (.*);

    always #10 clk = ~clk;

    function automatic logic [5:0] pcIndex(btbPkg::pcT pc);
        return pc[7:2];
    endfunction

    function automatic logic [7:0] pcTag(btbPkg::pcT pc);
        return pc[15:8];
    endfunction

    // PCs from a small window so that random lookups actually hit
    function automatic btbPkg::pcT poolPc();
        return $urandom & 32'h0000_03fc;
    endfunction

    function automatic logic matchesEntry(refEntryT e, logic [7:0] tag, int s);
        logic hit;
        hit = e.valid && (e.tag == tag);
        if (hit != btbHit[s]) begin
            return 1'b0;
        end
        return !hit || (btbTarget[s] == e.target && btbIsCondBr[s] == e.cond);
    endfunction

    always @(posedge clk) begin
        btbPkg::pcT slotPc;
        refEntryT   wrEntry;
        logic [5:0] wrIdx [PORTS];
        logic       wrOn  [PORTS];
        logic       queued;
        // Outputs now belong to the lookup sampled on the previous edge
        if (expOn) begin
            for (int s = 0; s < SLOTS; s++) begin
                checks++;
                lookupOk: assert (matchesEntry(expNow[s], expTag[s], s) ||
                                  (expAltOn[s] && matchesEntry(expAlt[s], expTag[s], s)))
                else begin
                    errors++;
                    $display("Mismatch at %0t: slot %0d got %0b %h %0b, expected %0b %h %0b",
                             $time, s, btbHit[s], btbTarget[s], btbIsCondBr[s],
                             expNow[s].valid && expNow[s].tag == expTag[s],
                             expNow[s].target, expNow[s].cond);
                end
            end
        end
        expOn = ready;
        for (int s = 0; s < SLOTS; s++) begin
            slotPc      = predNextPc + btbPkg::pcT'(s * btbPkg::INSN_BYTES);
            expTag[s]   = pcTag(slotPc);
            expNow[s]   = refTable[pcIndex(slotPc)];
            expAlt[s]   = pendEntry[pcIndex(slotPc)];
            expAltOn[s] = pendCnt[pcIndex(slotPc)] > 0;
        end
        for (int i = 0; i < btbPkg::ENTRY_NUM; i++) begin
            if (pendCnt[i] > 0) begin
                pendCnt[i]--;
                if (pendCnt[i] == 0) begin
                    refTable[i] = pendEntry[i];
                end
            end
        end
        if (ready) begin
            for (int i = 0; i < PORTS; i++) begin
                wrOn[i]  = brValid[i] && brTaken[i];
                wrIdx[i] = pcIndex(brAddr[i]);
            end
            // A later port sharing a bank with an earlier enabled port is queued
            for (int i = 0; i < PORTS; i++) begin
                queued = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (wrOn[i] && wrOn[j] && wrIdx[i][0] == wrIdx[j][0]) begin
                        queued = 1'b1;
                    end
                end
                wrEntry = '{1'b1, brIsCondBr[i], pcTag(brAddr[i]), {brNextAddr[i][31:2], 2'b00}};
                if (queued) begin
                    wrOn[i]             = 1'b0;
                    pendEntry[wrIdx[i]] = wrEntry;
                    pendCnt[wrIdx[i]]   = DRAIN_CYCLES;
                end else if (wrOn[i]) begin
                    refTable[wrIdx[i]] = wrEntry;
                end
            end
        end
    end

    readyHolds: assert property (@(posedge clk) disable iff (!rstN) ready |=> ready)
    else begin
        errors++;
        $display("Ready dropped after the sweep had finished");
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic clearBranches();
        for (int i = 0; i < PORTS; i++) begin
            brValid[i]    = 1'b0;
            brTaken[i]    = 1'b0;
            brIsCondBr[i] = 1'b0;
            brAddr[i]     = '0;
            brNextAddr[i] = '0;
        end
    endtask

    // Branch results are one-cycle pulses
    task automatic nextCycle();
        @(posedge clk);
        #2;
        clearBranches();
    endtask

    task automatic sendBranch(int port, btbPkg::pcT addr, btbPkg::pcT next, logic taken,
                              logic cond);
        brValid[port]    = 1'b1;
        brTaken[port]    = taken;
        brIsCondBr[port] = cond;
        brAddr[port]     = addr;
        brNextAddr[port] = next;
    endtask

    initial begin
        int waited;
        int quiet;
        void'($urandom(32'h718b));
        clk        = 1'b0;
        rstN       = 1'b0;
        predNextPc = '0;
        waited     = 0;
        quiet      = 0;
        clearBranches();
        for (int i = 0; i < btbPkg::ENTRY_NUM; i++) begin
            refTable[i]  = '0;
            pendEntry[i] = '0;
            pendCnt[i]   = 0;
        end
        repeat (10) @(posedge clk);
        #2 rstN = 1'b1;
        while (!ready && waited < 70) begin
            @(posedge clk);
            waited++;
        end
        readyInTime: assert (ready) else begin
            errors++;
            $display("Ready did not rise within 70 cycles of reset release");
        end

        // Cleared table misses everywhere
        repeat (20) begin
            nextCycle();
            predNextPc = $urandom;
        end

        // Single taken branch, seen in slot 0 and then in slot 1
        nextCycle();
        sendBranch(0, 32'h0000_1230, 32'h0000_4560, 1'b1, 1'b1);
        predNextPc = 32'h0000_1230;
        nextCycle();
        predNextPc = 32'h0000_1230;
        nextCycle();
        predNextPc = 32'h0000_122c;

        // Not taken and invalid results change nothing
        nextCycle();
        sendBranch(0, 32'h0000_2000, 32'h0000_7000, 1'b0, 1'b1);
        sendBranch(1, 32'h0000_2004, 32'h0000_7100, 1'b1, 1'b0);
        brValid[1] = 1'b0;
        nextCycle();
        predNextPc = 32'h0000_2000;

        // Same bank, different index: port 1 goes through the queue
        nextCycle();
        sendBranch(0, 32'h0000_3008, 32'h0000_8000, 1'b1, 1'b0);
        sendBranch(1, 32'h0000_3010, 32'h0000_9000, 1'b1, 1'b1);
        nextCycle();
        predNextPc = 32'h0000_3008;
        repeat (DRAIN_CYCLES + 1) begin
            nextCycle();
            predNextPc = 32'h0000_3010;
        end

        // Tag aliasing on one index, then an overwrite
        nextCycle();
        sendBranch(1, 32'h0000_4a40, 32'hbeef_0000, 1'b1, 1'b1);
        nextCycle();
        predNextPc = 32'h0000_4a40;
        nextCycle();
        predNextPc = 32'h0000_4b40;
        sendBranch(0, 32'h0000_4b40, 32'h1111_1110, 1'b1, 1'b0);
        nextCycle();
        predNextPc = 32'h0000_4a40;
        nextCycle();
        predNextPc = 32'h0000_4b40;

        // Random traffic with a quiet drain window after each bank conflict
        repeat (RANDOM_CYCLES) begin
            nextCycle();
            predNextPc = poolPc();
            if (quiet > 0) begin
                quiet--;
            end else begin
                for (int i = 0; i < PORTS; i++) begin
                    sendBranch(i, poolPc(), $urandom, $urandom_range(3, 0) != 0,
                               $urandom_range(1, 0) != 0);
                    brValid[i] = ($urandom_range(3, 0) != 0);
                end
                for (int i = 1; i < PORTS; i++) begin
                    for (int j = 0; j < i; j++) begin
                        if (brValid[i] && brTaken[i] && brValid[j] && brTaken[j] &&
                            brAddr[i][2] == brAddr[j][2]) begin
                            quiet = DRAIN_CYCLES;
                        end
                    end
                end
            end
        end

        nextCycle();
        nextCycle();
        $display("Lookup checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* build.f */
verilog/btbPkg.sv
verilog/btbWriteIf.sv
verilog/multiBankRam.sv
verilog/btbUpdateArbiter.sv
verilog/btbReadStage.sv
verilog/btb.sv
dv/btbTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := btbTb
FILELIST   := build.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
LOG        := sim.log
PASS_MSG   := Finished with no errors
FAIL_MSG   := Finished with errors
SIM        := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
